//--- synctimer_adjust.f
+incdir+design
design/synctimer_pkg.sv
design/adjust_req_if.sv
design/cycle_estimator.sv
design/error_estimator.sv
design/divider_multicycle.sv
design/adjust_pulse_gen.sv
design/synctimer_adjust.sv
tests/synctimer_adjust_asserts.sv
tests/tb_synctimer_adjust.sv

//--- run_sim.sh
#!/bin/sh
# build and run the rate adjust testbench with Verilator

cd "$(dirname "$0")" || exit 1

BUILD_LOG=build.log
SIM_LOG=sim.log

verilator --binary --timing --assert -Wno-fatal \
    --top-module tb_synctimer_adjust \
    -f synctimer_adjust.f \
    -o sim_synctimer_adjust > "$BUILD_LOG" 2>&1
if [ $? -ne 0 ]; then
    cat "$BUILD_LOG"
    echo "verilator build failed"
    exit 1
fi

./obj_dir/sim_synctimer_adjust > "$SIM_LOG" 2>&1
status=$?
cat "$SIM_LOG"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "TESTS FAILED" "$SIM_LOG"; then
    exit 1
fi
exit 0

//--- tests/tb_synctimer_adjust.sv
// rate adjust testbench
`timescale 1ns/1ps
`include "synctimer_params.svh"

module tb_synctimer_adjust;

    localparam int PHASE_OFFSET = 2000;    // large enough to stay in the limiter

    logic                                    clk;
    logic                                    reset;
    synctimer_pkg::time_t                    current_time;
    synctimer_pkg::time_t                    correct_time;
    logic                                    correct_valid;
    logic signed [`SYNCTIMER_ERROR_WIDTH-1:0] adjust_min;
    logic signed [`SYNCTIMER_ERROR_WIDTH-1:0] adjust_max;
    logic                                    adjust_sign;
    logic                                    adjust_valid;
    logic                                    adjust_ready;

    int                    error_count;
    int                    timeout_count;
    int                    interval_len;
    int                    cycles_left;
    int                    phase_offset;
    bit                    corrections_on;
    logic                  ready_next;
    synctimer_pkg::count_t pos_pulses;
    synctimer_pkg::count_t neg_pulses;

    synctimer_adjust DUT (
        .clk           (clk),
        .reset         (reset),
        .current_time  (current_time),
        .correct_time  (correct_time),
        .correct_valid (correct_valid),
        .adjust_min    (adjust_min),
        .adjust_max    (adjust_max),
        .adjust_sign   (adjust_sign),
        .adjust_valid  (adjust_valid),
        .adjust_ready  (adjust_ready)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    // ---------------------------------------------------------------------
    // one clock: drive after the edge, then count accepted pulses
    task automatic tick();
        @(posedge clk);
        #1;
        current_time  = current_time + 1;
        adjust_ready  = ready_next;
        correct_valid = 1'b0;
        if (corrections_on) begin
            cycles_left = cycles_left - 1;
            if (cycles_left == 0) begin
                correct_valid = 1'b1;
                correct_time  = current_time + synctimer_pkg::time_t'(phase_offset);
                cycles_left   = interval_len;
            end
        end
        if (adjust_valid && adjust_ready) begin
            if (adjust_sign) begin
                neg_pulses = neg_pulses + 1;
            end else begin
                pos_pulses = pos_pulses + 1;
            end
        end
    endtask

    task automatic check_bit(input string test_name, input logic expected, input logic actual);
        if (actual !== expected) begin
            error_count++;
            $display("FAILED %s: expected %b, actual %b", test_name, expected, actual);
        end
    endtask

    task automatic check_count(input string test_name, input synctimer_pkg::count_t expected,
                               input synctimer_pkg::count_t margin,
                               input synctimer_pkg::count_t actual);
        if (actual + margin < expected || actual > expected + margin) begin
            error_count++;
            $display("FAILED %s: expected %0d (+/-%0d), actual %0d",
                     test_name, expected, margin, actual);
        end
    endtask

    task automatic apply_reset(output logic valid_seen);
        reset          = 1'b1;
        corrections_on = 1'b0;
        ready_next     = 1'b1;
        valid_seen     = 1'b0;
        repeat (10) begin
            tick();
            valid_seen = valid_seen | adjust_valid;
        end
        reset = 1'b0;
    endtask

    task automatic start_corrections(input int offset);
        phase_offset   = offset;
        interval_len   = $urandom_range(3000, 2000);
        cycles_left    = interval_len;
        corrections_on = 1'b1;
    endtask

    // counts pulses up to and including the next correction
    task automatic run_interval(input string test_name);
        int n;
        pos_pulses = '0;
        neg_pulses = '0;
        for (n = 0; n <= interval_len + 10; n++) begin
            tick();
            if (correct_valid) begin
                return;
            end
        end
        timeout_count++;
        $display("timeout in %s: no correction after %0d cycles", test_name, n);
    endtask

    task automatic settle_and_count(input string test_name, input int offset,
                                    input int lim_min, input int lim_max,
                                    input synctimer_pkg::count_t expected, input logic sign);
        logic seen;
        apply_reset(seen);
        check_bit({test_name, " in reset"}, 1'b0, seen);
        adjust_min = lim_min;
        adjust_max = lim_max;
        start_corrections(offset);
        repeat (20) run_interval(test_name);
        repeat (5) begin
            run_interval(test_name);
            check_count(test_name, expected, 1, sign ? neg_pulses : pos_pulses);
            check_count({test_name, " sign"}, 0, 0, sign ? pos_pulses : neg_pulses);
        end
    endtask

    // ---------------------------------------------------------------------
    // directed tests
    task automatic reset_idle();
        logic seen;
        apply_reset(seen);
        check_bit("reset_idle in reset", 1'b0, seen);
        seen = 1'b0;
        repeat (2000) begin
            tick();
            seen = seen | adjust_valid;
        end
        check_bit("reset_idle", 1'b0, seen);
    endtask

    task automatic zero_error();
        logic                  seen;
        synctimer_pkg::count_t total;
        apply_reset(seen);
        check_bit("zero_error in reset", 1'b0, seen);
        adjust_min = -3;
        adjust_max = 3;
        start_corrections(0);
        total = '0;
        repeat (12) begin
            run_interval("zero_error");
            total = total + pos_pulses + neg_pulses;
        end
        pos_pulses = '0;
        neg_pulses = '0;
        repeat (200) tick();        // last request and division
        total = total + pos_pulses + neg_pulses;
        check_count("zero_error", 0, 0, total);
    endtask

    task automatic positive_clamp();
        settle_and_count("positive_clamp", PHASE_OFFSET, -3, 3, 3, 1'b0);
    endtask

    task automatic negative_clamp();
        settle_and_count("negative_clamp", -PHASE_OFFSET, -2, 3, 2, 1'b1);
    endtask

    task automatic backpressure();
        logic held;
        int   n;
        held       = 1'b1;
        ready_next = 1'b0;
        tick();
        n = 0;
        while (!adjust_valid && n < 2 * interval_len) begin
            tick();
            n++;
        end
        if (!adjust_valid) begin
            timeout_count++;
            $display("timeout in backpressure: adjust_valid never rose");
            ready_next = 1'b1;
            return;
        end
        repeat (300) begin
            tick();
            held = held & adjust_valid;
        end
        check_bit("backpressure hold", 1'b1, held);
        ready_next = 1'b1;
        tick();
        check_bit("backpressure accept", 1'b1, adjust_valid);
        tick();
        check_bit("backpressure release", 1'b0, adjust_valid);
    endtask

    initial begin
        void'($urandom(32'h72be_90be));
        reset          = 1'b1;
        current_time   = '0;
        correct_time   = '0;
        correct_valid  = 1'b0;
        adjust_min     = -3;
        adjust_max     = 3;
        adjust_ready   = 1'b1;
        ready_next     = 1'b1;
        corrections_on = 1'b0;
        phase_offset   = 0;
        interval_len   = 2000;
        cycles_left    = 0;
        pos_pulses     = '0;
        neg_pulses     = '0;
        error_count    = 0;
        timeout_count  = 0;

        reset_idle();
        zero_error();
        positive_clamp();
        backpressure();     // corrections from positive_clamp still running
        negative_clamp();

        $display("summary: %0d value errors, %0d timeouts", error_count, timeout_count);
        if (error_count == 0 && timeout_count == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

endmodule

//--- tests/synctimer_adjust_asserts.sv
// rate adjust assertions
`timescale 1ns/1ps

module synctimer_adjust_asserts (
    input logic clk,
    input logic reset,
    input logic adjust_valid,
    input logic adjust_ready,
    input logic req_valid,
    input logic div_ready
);

    // output cleared by a reset edge
    assert property (@(posedge clk) reset |=> !adjust_valid)
        else $error("adjust_valid high after a reset cycle");

    // pulse held until accepted
    assert property (@(posedge clk) disable iff (reset)
        adjust_valid && !adjust_ready |=> adjust_valid)
        else $error("adjust_valid dropped without adjust_ready");

    assert property (@(posedge clk) disable iff (reset) req_valid |-> div_ready)
        else $error("division request while divider busy");

endmodule

bind synctimer_adjust synctimer_adjust_asserts u_asserts (
    .clk          (clk),
    .reset        (reset),
    .adjust_valid (adjust_valid),
    .adjust_ready (adjust_ready),
    .req_valid    (req_if.req_valid),
    .div_ready    (u_pulse_gen.u_divider.s_ready)
);

//--- design/synctimer_adjust.sv
// synchronized timer rate adjust
`timescale 1ns/1ps
`include "synctimer_params.svh"

module synctimer_adjust (
    input  logic                                    clk,
    input  logic                                    reset,
    input  synctimer_pkg::time_t                    current_time,
    input  synctimer_pkg::time_t                    correct_time,
    input  logic                                    correct_valid,
    input  logic signed [`SYNCTIMER_ERROR_WIDTH-1:0] adjust_min,
    input  logic signed [`SYNCTIMER_ERROR_WIDTH-1:0] adjust_max,
    output logic                                    adjust_sign,
    output logic                                    adjust_valid,
    input  logic                                    adjust_ready
);

    synctimer_pkg::cycle_t cycle_estimate;

    adjust_req_if req_if ();

    cycle_estimator u_cycle_estimator (
        .clk                  (clk),
        .reset                (reset),
        .correct_valid        (correct_valid),
        .cycle_estimate       (cycle_estimate),
        .cycle_estimate_valid ()
    );

    error_estimator u_error_estimator (
        .clk            (clk),
        .reset          (reset),
        .current_time   (current_time),
        .correct_time   (correct_time),
        .correct_valid  (correct_valid),
        .adjust_min     (adjust_min),
        .adjust_max     (adjust_max),
        .cycle_estimate (cycle_estimate),
        .req            (req_if.source)
    );

    adjust_pulse_gen u_pulse_gen (
        .clk          (clk),
        .reset        (reset),
        .req          (req_if.sink),
        .adjust_sign  (adjust_sign),
        .adjust_valid (adjust_valid),
        .adjust_ready (adjust_ready)
    );

endmodule

//--- design/adjust_pulse_gen.sv
// adjust pulse generator
`timescale 1ns/1ps
`include "synctimer_params.svh"

module adjust_pulse_gen (
    input  logic       clk,
    input  logic       reset,
    adjust_req_if.sink req,
    output logic       adjust_sign,
    output logic       adjust_valid,
    input  logic       adjust_ready
);

    // cycle fraction bits up to error plus period fraction bits
    localparam int CYCLE_SHIFT =
        `SYNCTIMER_ERROR_Q + `SYNCTIMER_ADJUST_Q - `SYNCTIMER_LPF_GAIN_CYCLE;
    localparam synctimer_pkg::adjust_t STEP = synctimer_pkg::adjust_t'(1) << `SYNCTIMER_ADJUST_Q;

    synctimer_pkg::dividend_t div_dividend;
    synctimer_pkg::adjust_t   div_quotient;
    logic                     div_valid;

    logic                   new_pending;   // period waiting for next event
    logic                   new_zero;
    logic                   new_sign;
    synctimer_pkg::adjust_t new_period;

    logic                   cur_zero;
    logic                   cur_sign;
    synctimer_pkg::adjust_t cur_period;
    synctimer_pkg::adjust_t acc_count;
    synctimer_pkg::adjust_t acc_next;
    logic                   acc_event;

    assign div_dividend = synctimer_pkg::dividend_t'(req.req_cycle) << CYCLE_SHIFT;

    divider_multicycle #(
        .DIVIDEND_WIDTH ($bits(synctimer_pkg::dividend_t)),
        .DIVISOR_WIDTH  ($bits(synctimer_pkg::error_mag_t)),
        .QUOTIENT_WIDTH ($bits(synctimer_pkg::adjust_t))
    ) u_divider (
        .clk         (clk),
        .reset       (reset),
        .s_dividend  (div_dividend),
        .s_divisor   (req.req_magnitude),
        .s_valid     (req.req_valid),
        .s_ready     (),
        .m_quotient  (div_quotient),
        .m_remainder (),
        .m_valid     (div_valid)
    );

    // ---------------------------------------------------------------------
    // period register, one step less for the reload cycle
    always_ff @(posedge clk) begin
        if (reset) begin
            new_pending <= 1'b0;
            new_zero    <= 1'b1;
        end else begin
            if (acc_event) begin
                new_pending <= 1'b0;
            end
            if (div_valid) begin
                new_pending <= 1'b1;
                new_zero    <= req.req_zero;
                new_sign    <= req.req_sign;
                if (req.req_zero) begin
                    new_period <= '0;       // events keep running for later updates
                end else begin
                    new_period <= div_quotient - STEP;
                end
            end
        end
    end

    // ---------------------------------------------------------------------
    // fixed point accumulator
    always_ff @(posedge clk) begin
        if (reset) begin
            cur_zero   <= 1'b1;
            cur_period <= '0;
            acc_count  <= '0;
            acc_event  <= 1'b0;
        end else begin
            acc_count <= acc_count + STEP;
            acc_next  <= acc_count - cur_period;     // keeps the remainder
            acc_event <= acc_count >= cur_period;
            if (acc_event) begin
                acc_event <= 1'b0;
                if (new_pending) begin
                    cur_zero   <= new_zero;
                    cur_sign   <= new_sign;
                    cur_period <= new_period;
                    acc_count  <= '0;
                end else begin
                    acc_count <= acc_next;
                end
            end
        end
    end

    // output, held until accepted
    always_ff @(posedge clk) begin
        if (reset) begin
            adjust_valid <= 1'b0;
        end else begin
            if (adjust_ready) begin
                adjust_valid <= 1'b0;
            end
            if (acc_event && !cur_zero) begin
                adjust_valid <= 1'b1;
                adjust_sign  <= cur_sign;      // merges into a pending pulse
            end
        end
    end

endmodule

//--- design/divider_multicycle.sv
// multicycle unsigned divider
`timescale 1ns/1ps

module divider_multicycle #(
    parameter int DIVIDEND_WIDTH = 32,
    parameter int DIVISOR_WIDTH  = 32,
    parameter int QUOTIENT_WIDTH = 32
) (
    input  logic                      clk,
    input  logic                      reset,
    input  logic [DIVIDEND_WIDTH-1:0] s_dividend,
    input  logic [DIVISOR_WIDTH-1:0]  s_divisor,
    input  logic                      s_valid,
    output logic                      s_ready,
    output logic [QUOTIENT_WIDTH-1:0] m_quotient,
    output logic [DIVISOR_WIDTH-1:0]  m_remainder,
    output logic                      m_valid
);

    localparam int SHIFT_WIDTH = DIVISOR_WIDTH + QUOTIENT_WIDTH - 1;
    localparam int WORK_WIDTH  = (DIVIDEND_WIDTH > SHIFT_WIDTH) ? DIVIDEND_WIDTH : SHIFT_WIDTH;
    localparam int STEP_WIDTH  = $clog2(QUOTIENT_WIDTH + 1);

    logic [WORK_WIDTH-1:0] work_rem;    // partial remainder
    logic [WORK_WIDTH-1:0] work_div;    // divisor aligned to current bit
    logic                  work_ge;
    logic [STEP_WIDTH-1:0] step_left;
    logic                  busy;

    assign work_ge     = work_rem >= work_div;
    assign s_ready     = ~busy;
    assign m_remainder = work_rem[DIVISOR_WIDTH-1:0];

    // quotient assumed to fit in QUOTIENT_WIDTH bits
    always_ff @(posedge clk) begin
        if (reset) begin
            busy    <= 1'b0;
            m_valid <= 1'b0;
        end else begin
            m_valid <= 1'b0;
            if (s_valid && !busy) begin
                busy      <= 1'b1;
                step_left <= STEP_WIDTH'(QUOTIENT_WIDTH);
                work_rem  <= WORK_WIDTH'(s_dividend);
                work_div  <= WORK_WIDTH'(s_divisor) << (QUOTIENT_WIDTH - 1);
            end else if (busy) begin
                if (work_ge) begin
                    work_rem <= work_rem - work_div;
                end
                work_div   <= work_div >> 1;
                m_quotient <= {m_quotient[QUOTIENT_WIDTH-2:0], work_ge};  // msb first
                step_left  <= step_left - STEP_WIDTH'(1);
                if (step_left == STEP_WIDTH'(1)) begin
                    busy    <= 1'b0;
                    m_valid <= 1'b1;
                end
            end
        end
    end

endmodule

//--- design/error_estimator.sv
// phase and period error estimator
`timescale 1ns/1ps
`include "synctimer_params.svh"

module error_estimator (
    input  logic                                    clk,
    input  logic                                    reset,
    input  synctimer_pkg::time_t                    current_time,
    input  synctimer_pkg::time_t                    correct_time,
    input  logic                                    correct_valid,
    input  logic signed [`SYNCTIMER_ERROR_WIDTH-1:0] adjust_min,
    input  logic signed [`SYNCTIMER_ERROR_WIDTH-1:0] adjust_max,
    input  synctimer_pkg::cycle_t                   cycle_estimate,
    adjust_req_if.source                            req
);

    typedef logic [6:0] error_stage_t;

    localparam int GAIN_X = `SYNCTIMER_LPF_GAIN_PHASE;
    localparam int GAIN_V = `SYNCTIMER_LPF_GAIN_PERIOD;

    error_stage_t          stage;           // one-hot
    synctimer_pkg::time_t  time_diff;
    synctimer_pkg::error_t limit_min;
    synctimer_pkg::error_t limit_max;

    synctimer_pkg::error_t observe_x;       // phase error
    synctimer_pkg::error_t predict_x;
    logic                  predict_x_en;
    synctimer_pkg::error_t lpf_x;
    logic                  lpf_x_en;
    synctimer_pkg::error_t estimate_x;
    logic                  estimate_x_en;
    synctimer_pkg::error_t estimate_x0;     // previous correction
    logic                  estimate_x0_en;

    synctimer_pkg::error_t observe_v;       // period error
    logic                  observe_v_en;
    synctimer_pkg::error_t lpf_v;
    logic                  lpf_v_en;
    synctimer_pkg::error_t estimate_v;
    logic                  estimate_v_en;
    synctimer_pkg::error_t estimate_v0;
    logic                  estimate_v0_en;

    synctimer_pkg::error_t adjust_total;
    synctimer_pkg::error_t adjust_value;    // control per interval
    synctimer_pkg::error_t clamp_value;

    assign time_diff = correct_time - current_time;
    assign limit_min = synctimer_pkg::error_t'(adjust_min) <<< `SYNCTIMER_ERROR_Q;
    assign limit_max = synctimer_pkg::error_t'(adjust_max) <<< `SYNCTIMER_ERROR_Q;

    // limiter
    always_comb begin
        clamp_value = adjust_total;
        if (adjust_total < limit_min) begin
            clamp_value = limit_min;
        end
        if (adjust_total > limit_max) begin
            clamp_value = limit_max;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            stage          <= '0;
            predict_x_en   <= 1'b0;
            lpf_x_en       <= 1'b0;
            estimate_x_en  <= 1'b0;
            estimate_x0_en <= 1'b0;
            observe_v_en   <= 1'b0;
            lpf_v_en       <= 1'b0;
            estimate_v_en  <= 1'b0;
            estimate_v0_en <= 1'b0;
            adjust_value   <= '0;
            req.req_valid  <= 1'b0;
        end else begin
            stage <= stage << 1;
            if (correct_valid) begin
                stage[0]       <= 1'b1;
                observe_x      <= synctimer_pkg::error_t'($signed(time_diff)) <<< `SYNCTIMER_ERROR_Q;
                estimate_x0    <= estimate_x;
                estimate_x0_en <= estimate_x_en;
                estimate_v0    <= estimate_v;
                estimate_v0_en <= estimate_v_en;
            end

            // ----------------------------------------------------------------
            // phase
            if (stage[0]) begin
                predict_x    <= estimate_x0 + estimate_v0 - adjust_value;
                predict_x_en <= estimate_x0_en & estimate_v0_en;
            end
            if (stage[1]) begin
                lpf_x    <= predict_x - (predict_x >>> GAIN_X);
                lpf_x_en <= predict_x_en;
            end
            if (stage[2]) begin
                estimate_x    <= lpf_x_en ? lpf_x + (observe_x >>> GAIN_X) : observe_x;
                estimate_x_en <= 1'b1;
            end

            // ----------------------------------------------------------------
            // period
            if (stage[3]) begin
                observe_v    <= estimate_x - (estimate_x0 - adjust_value);
                observe_v_en <= estimate_x_en & estimate_x0_en;
                lpf_v        <= estimate_v0 - (estimate_v0 >>> GAIN_V);
                lpf_v_en     <= estimate_v0_en;
            end
            if (stage[4] && observe_v_en) begin
                estimate_v    <= lpf_v_en ? lpf_v + (observe_v >>> GAIN_V) : observe_v;
                estimate_v_en <= 1'b1;
            end

            // ----------------------------------------------------------------
            // control value and request
            if (stage[5]) begin
                adjust_total <= estimate_x + estimate_v;
            end
            req.req_valid <= 1'b0;
            if (stage[6] && estimate_v_en) begin
                adjust_value <= clamp_value;
                if (estimate_v0_en) begin
                    req.req_valid     <= 1'b1;
                    req.req_sign      <= clamp_value < 0;
                    req.req_zero      <= clamp_value == 0;
                    req.req_magnitude <= (clamp_value < 0) ?
                        synctimer_pkg::error_mag_t'(-clamp_value) :
                        synctimer_pkg::error_mag_t'(clamp_value);
                    req.req_cycle     <= cycle_estimate;
                end
            end
        end
    end

endmodule

//--- design/cycle_estimator.sv
// local cycle estimator
`timescale 1ns/1ps
`include "synctimer_params.svh"

module cycle_estimator (
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  correct_valid,
    output synctimer_pkg::cycle_t cycle_estimate,
    output logic                  cycle_estimate_valid
);

    localparam int GAIN = `SYNCTIMER_LPF_GAIN_CYCLE;

    synctimer_pkg::count_t count_cycle;
    logic                  count_enable;    // first correction seen
    logic                  observe_valid;
    synctimer_pkg::cycle_t cycle_observe;
    synctimer_pkg::cycle_t cycle_lpf;       // estimate * (1 - 1/2^N)

    // cycles since the last correction
    always_ff @(posedge clk) begin
        if (correct_valid) begin
            count_cycle <= synctimer_pkg::count_t'(1);
        end else begin
            count_cycle <= count_cycle + synctimer_pkg::count_t'(1);
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            count_enable         <= 1'b0;
            observe_valid        <= 1'b0;
            cycle_estimate_valid <= 1'b0;
        end else begin
            if (correct_valid) begin
                count_enable <= 1'b1;
            end
            observe_valid <= correct_valid & count_enable;
            if (observe_valid) begin
                cycle_estimate_valid <= 1'b1;
            end
        end
    end

    // observation latch, then blend into the estimate
    always_ff @(posedge clk) begin
        if (correct_valid) begin
            cycle_observe <= synctimer_pkg::cycle_t'(count_cycle) << GAIN;
            cycle_lpf     <= cycle_estimate - (cycle_estimate >> GAIN);
        end
        if (observe_valid) begin
            if (cycle_estimate_valid) begin
                cycle_estimate <= cycle_lpf + (cycle_observe >> GAIN);
            end else begin
                cycle_estimate <= cycle_observe;    // first one unfiltered
            end
        end
    end

endmodule

//--- design/adjust_req_if.sv
// adjust request interface
`timescale 1ns/1ps

interface adjust_req_if;

    logic                      req_sign;       // control value negative
    logic                      req_zero;       // control value zero
    synctimer_pkg::error_mag_t req_magnitude;
    synctimer_pkg::cycle_t     req_cycle;      // cycle estimate snapshot
    logic                      req_valid;      // single cycle strobe, no ready

    modport source (
        output req_sign,
        output req_zero,
        output req_magnitude,
        output req_cycle,
        output req_valid
    );

    modport sink (
        input req_sign,
        input req_zero,
        input req_magnitude,
        input req_cycle,
        input req_valid
    );

endinterface

//--- design/synctimer_pkg.sv
// synchronized timer types
`include "synctimer_params.svh"

package synctimer_pkg;

    typedef logic [`SYNCTIMER_TIMER_WIDTH-1:0] time_t;
    typedef logic [`SYNCTIMER_CYCLE_WIDTH-1:0] count_t;

    // filtered cycle count, LPF_GAIN_CYCLE fraction bits
    typedef logic [`SYNCTIMER_CYCLE_WIDTH+`SYNCTIMER_LPF_GAIN_CYCLE-1:0] cycle_t;

    typedef logic signed [`SYNCTIMER_ERROR_WIDTH+`SYNCTIMER_ERROR_Q-1:0] error_t;
    typedef logic [`SYNCTIMER_ERROR_WIDTH+`SYNCTIMER_ERROR_Q-1:0] error_mag_t;

    // cycle estimate with error and period fractions
    typedef logic [`SYNCTIMER_CYCLE_WIDTH+`SYNCTIMER_ERROR_Q+`SYNCTIMER_ADJUST_Q-1:0] dividend_t;

    typedef logic [`SYNCTIMER_CYCLE_WIDTH+`SYNCTIMER_ERROR_Q+`SYNCTIMER_ADJUST_Q-1:0] adjust_t;

endpackage

//--- design/synctimer_params.svh
// synchronized timer parameters
`ifndef SYNCTIMER_PARAMS_SVH
`define SYNCTIMER_PARAMS_SVH

// widths
`define SYNCTIMER_TIMER_WIDTH 32
`define SYNCTIMER_CYCLE_WIDTH 32
`define SYNCTIMER_ERROR_WIDTH 32

// fixed point fraction bits of the error and of the pulse period
`define SYNCTIMER_ERROR_Q  8
`define SYNCTIMER_ADJUST_Q 8

// low pass filter gains, 1/2^N
`define SYNCTIMER_LPF_GAIN_CYCLE  6
`define SYNCTIMER_LPF_GAIN_PHASE  6
`define SYNCTIMER_LPF_GAIN_PERIOD 6

`endif
